// ==== Makefile ====
# Verilator flow for the dual channel buffer, override any variable on the command line

VERILATOR ?= verilator
TOP       ?= tb_dual_chan_buffer
LINT_TOP  ?= dual_chan_buffer
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides, the simulator exit code is not trusted
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== logic/buf_pkg.sv ====
// shared sizes, flag thresholds and sample types for the dual channel buffer, compile before all RTL
package buf_pkg;

    // ******************************************************************
    // sizes
    // ******************************************************************

    localparam int NUM_CH  = 2;   // I and Q streams
    localparam int DEPTH_W = 4;   // 16 entries per queue
    localparam int DATA_W  = 16;  // one sample word

    // ******************************************************************
    // water level thresholds
    // ******************************************************************

    // almost_full once the level reaches this count
    localparam int ALMOST_FULL_NUM  = 14;
    // almost_empty while the level sits at or below this count
    localparam int ALMOST_EMPTY_NUM = 2;

    // ******************************************************************
    // types
    // ******************************************************************

    // channel tag, also the region select bit of the shared memory
    typedef enum logic
    {
        CH_I = 1'b0,    // in-phase
        CH_Q = 1'b1     // quadrature
    } chan_e;

    // one sample as stored and read back
    typedef logic [DATA_W-1:0] data_t;

    // offset inside one queue region
    typedef logic [DEPTH_W-1:0] addr_t;

    // fill count, one bit wider so a full queue reads 16
    typedef logic [DEPTH_W:0] level_t;

endpackage

// ==== logic/dual_chan_buffer.sv ====
// top of the two channel FFT input buffer, connects both queue controllers, arbiter and memory
`timescale 1ns/1ps

module dual_chan_buffer (
    input  logic                        rclk,
    input  logic                        rrst,
    // write stream
    input  logic                        wr_en,
    input  buf_pkg::chan_e              wr_chan,
    input  buf_pkg::data_t              wr_data,
    // read stream
    input  logic                        out_hold,
    output logic                        out_valid,
    output buf_pkg::chan_e              out_chan,
    output buf_pkg::data_t              out_data,
    // status, bit 0 is I and bit 1 is Q
    output logic [buf_pkg::NUM_CH-1:0]  full,
    output logic [buf_pkg::NUM_CH-1:0]  almost_full,
    output logic [buf_pkg::NUM_CH-1:0]  empty,
    output logic [buf_pkg::NUM_CH-1:0]  almost_empty,
    output buf_pkg::level_t             level_i,
    output buf_pkg::level_t             level_q,
    output logic [buf_pkg::NUM_CH-1:0]  wr_drop
);

    import buf_pkg::*;

    // ******************************************************************
    // per-channel links
    // ******************************************************************

    fifo_port_if if_i ();
    fifo_port_if if_q ();

    assign empty = {if_q.empty, if_i.empty};

    fifo_ctrl #(.CH_ID(CH_I)) u_ctrl_i (
        .rclk         (rclk),
        .rrst         (rrst),
        .wr_en        (wr_en),
        .wr_chan      (wr_chan),
        .port         (if_i),
        .full         (full[0]),
        .almost_full  (almost_full[0]),
        .almost_empty (almost_empty[0]),
        .level        (level_i),
        .wr_drop      (wr_drop[0])
    );

    fifo_ctrl #(.CH_ID(CH_Q)) u_ctrl_q (
        .rclk         (rclk),
        .rrst         (rrst),
        .wr_en        (wr_en),
        .wr_chan      (wr_chan),
        .port         (if_q),
        .full         (full[1]),
        .almost_full  (almost_full[1]),
        .almost_empty (almost_empty[1]),
        .level        (level_q),
        .wr_drop      (wr_drop[1])
    );

    // ******************************************************************
    // shared read path
    // ******************************************************************

    read_arbiter u_arb (
        .rclk      (rclk),
        .rrst      (rrst),
        .port_i    (if_i),
        .port_q    (if_q),
        .out_hold  (out_hold),
        .out_valid (out_valid),
        .out_chan  (out_chan)
    );

    shared_ram u_ram (
        .rclk     (rclk),
        .port_i   (if_i),
        .port_q   (if_q),
        .wr_chan  (wr_chan),
        .wr_data  (wr_data),
        .out_data (out_data)
    );

endmodule

// ==== logic/fifo_ctrl.sv ====
// pointer controller for one queue, instantiated once per channel with CH_ID picking its writes
`timescale 1ns/1ps

module fifo_ctrl #(
    parameter buf_pkg::chan_e CH_ID = buf_pkg::CH_I
) (
    input  logic            rclk,
    input  logic            rrst,
    input  logic            wr_en,
    input  buf_pkg::chan_e  wr_chan,
    fifo_port_if.ctrl       port,
    output logic            full,
    output logic            almost_full,
    output logic            almost_empty,
    output buf_pkg::level_t level,
    output logic            wr_drop
);

    import buf_pkg::*;

    // ******************************************************************
    // write decode
    // ******************************************************************

    logic             wr_hit;   // strobe tagged for this queue
    logic [DEPTH_W:0] wptr;     // binary, top bit is the wrap flag
    logic [DEPTH_W:0] rptr;
    logic [DEPTH_W:0] wbnext;   // pointer after this edge
    logic [DEPTH_W:0] rbnext;

    assign wr_hit   = wr_en && (wr_chan == CH_ID);
    assign port.wen = wr_hit && !full;   // full queue swallows the write

    // ******************************************************************
    // next pointers
    // ******************************************************************

    // ren arrives only while empty is low, so no empty test here
    assign wbnext = wptr + {{DEPTH_W{1'b0}}, port.wen};
    assign rbnext = rptr + {{DEPTH_W{1'b0}}, port.ren};

    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
        begin
            wptr <= '0;
            rptr <= '0;
        end
        else
        begin
            wptr <= wbnext;
            rptr <= rbnext;
        end
    end

    // memory addresses drop the wrap bit
    assign port.waddr = wptr[DEPTH_W-1:0];
    assign port.raddr = rptr[DEPTH_W-1:0];

    // ******************************************************************
    // registered flags and water level
    // ******************************************************************

    // all taken from the next pointers so they settle on the same edge
    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
        begin
            full       <= 1'b0;
            port.empty <= 1'b1;   // nothing stored yet
            level      <= '0;
            wr_drop    <= 1'b0;
        end
        else
        begin
            // wrap bits differ, offsets equal
            full       <= (wbnext[DEPTH_W] != rbnext[DEPTH_W]) &&
                          (wbnext[DEPTH_W-1:0] == rbnext[DEPTH_W-1:0]);
            port.empty <= (wbnext == rbnext);
            level      <= wbnext - rbnext;     // modulo 32 gives 0..16
            wr_drop    <= wr_hit && full;      // one pulse per lost sample
        end
    end

    // almost flags straight off the registered level
    assign almost_full  = (level >= level_t'(ALMOST_FULL_NUM));
    assign almost_empty = (level <= level_t'(ALMOST_EMPTY_NUM));

    // ******************************************************************
    // checks
    // ******************************************************************

    // arbiter must never pull from a drained queue
    a_no_ren_empty : assert property
    (
        @(posedge rclk) disable iff (rrst)
        port.ren |-> !port.empty
    )
    else $error("ren raised on empty queue %0d", CH_ID);

    // pointer spacing stays within one queue depth
    a_level_max : assert property
    (
        @(posedge rclk) disable iff (rrst)
        level <= (level_t'(1) << DEPTH_W)
    )
    else $error("level %0d over depth on queue %0d", level, CH_ID);

endmodule

// ==== logic/fifo_port_if.sv ====
// bundle between one queue controller, the shared memory and the read arbiter, one per channel
`timescale 1ns/1ps

interface fifo_port_if;

    import buf_pkg::*;

    // write side
    logic  wen;     // write strobe, full already masked out
    addr_t waddr;   // slot for the next stored sample

    // read side
    logic  ren;     // one-cycle grant from the arbiter
    addr_t raddr;   // head of the queue

    logic  empty;   // registered, from the next pointers

    // ******************************************************************
    // views
    // ******************************************************************

    // pointer controller owns both addresses and the empty flag
    modport ctrl
    (
        output wen, waddr, raddr, empty,
        input  ren
    );

    // memory only looks at strobes and addresses
    modport ram
    (
        input wen, waddr, ren, raddr
    );

    // arbiter watches empty, hands back the grant
    modport arb
    (
        input  empty,
        output ren
    );

endinterface

// ==== logic/read_arbiter.sv ====
// round-robin drain of the I and Q queues into one output stream, stalled by out_hold
`timescale 1ns/1ps

module read_arbiter (
    input  logic           rclk,
    input  logic           rrst,
    fifo_port_if.arb       port_i,
    fifo_port_if.arb       port_q,
    input  logic           out_hold,
    output logic           out_valid,
    output buf_pkg::chan_e out_chan
);

    import buf_pkg::*;

    logic  req_i;      // I has data and the sink accepts
    logic  req_q;
    logic  gnt_i;
    logic  gnt_q;
    chan_e last_gnt;   // channel served by the latest grant

    // ******************************************************************
    // grant
    // ******************************************************************

    assign req_i = !port_i.empty && !out_hold;
    assign req_q = !port_q.empty && !out_hold;

    always_comb
    begin
        gnt_i = 1'b0;
        gnt_q = 1'b0;
        if (req_i && req_q)
        begin
            // both waiting, serve the one skipped last time
            if (last_gnt == CH_I)
                gnt_q = 1'b1;
            else
                gnt_i = 1'b1;
        end
        else
        begin
            gnt_i = req_i;   // lone requester wins
            gnt_q = req_q;
        end
    end

    assign port_i.ren = gnt_i;
    assign port_q.ren = gnt_q;

    // ******************************************************************
    // output tracking, one cycle behind the grant
    // ******************************************************************

    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
        begin
            last_gnt  <= CH_Q;   // so I goes first after reset
            out_valid <= 1'b0;
            out_chan  <= CH_I;
        end
        else
        begin
            out_valid <= gnt_i || gnt_q;   // memory read lands now
            if (gnt_i || gnt_q)
            begin
                last_gnt <= gnt_q ? CH_Q : CH_I;
                out_chan <= gnt_q ? CH_Q : CH_I;
            end
        end
    end

    // single shared read port, never two grants
    a_one_ren : assert property
    (
        @(posedge rclk) disable iff (rrst)
        $onehot0({port_i.ren, port_q.ren})
    )
    else $error("both queues granted in one cycle");

endmodule

// ==== logic/shared_ram.sv ====
// dual-port sample memory shared by both queues, the channel bit selects each queue's region
`timescale 1ns/1ps

module shared_ram (
    input  logic            rclk,
    fifo_port_if.ram        port_i,
    fifo_port_if.ram        port_q,
    input  buf_pkg::chan_e  wr_chan,
    input  buf_pkg::data_t  wr_data,
    output buf_pkg::data_t  out_data
);

    import buf_pkg::*;

    data_t mem [NUM_CH << DEPTH_W];   // 32 words, I low half, Q high half

    logic             we;
    logic             re;
    addr_t            wr_off;   // offset from the tagged controller
    logic [DEPTH_W:0] wa;       // {region, offset}
    logic [DEPTH_W:0] ra;

    // ******************************************************************
    // port muxing
    // ******************************************************************

    // at most one wen, the tag already picked the queue
    assign we     = port_i.wen || port_q.wen;
    assign wr_off = (wr_chan == CH_Q) ? port_q.waddr : port_i.waddr;
    assign wa     = {wr_chan, wr_off};

    // arbiter grants one ren at a time
    assign re = port_i.ren || port_q.ren;
    assign ra = port_q.ren ? {CH_Q, port_q.raddr} : {CH_I, port_i.raddr};

    // ******************************************************************
    // storage
    // ******************************************************************

    always_ff @(posedge rclk)
    begin
        if (we)
            mem[wa] <= wr_data;
        if (re)
            out_data <= mem[ra];   // registered read, one cycle latency
    end

endmodule

// ==== sim.f ====
logic/buf_pkg.sv
logic/fifo_port_if.sv
logic/fifo_ctrl.sv
logic/read_arbiter.sv
logic/shared_ram.sv
logic/dual_chan_buffer.sv
verif/tb_dual_chan_buffer.sv

// ==== verif/tb_dual_chan_buffer.sv ====
// self-checking testbench for the dual channel buffer, random and directed traffic against a queue model
`timescale 1ns/1ps

module tb_dual_chan_buffer;

    import buf_pkg::*;

    localparam int CLK_PERIOD  = 4;
    localparam int RST_CYCLES  = 8;
    localparam int N_RAND      = 400;
    localparam int DRAIN_MAX   = 40;                // 32 stored beats plus latency
    localparam int DEPTH       = 1 << DEPTH_W;
    // reset, random, the four directed loads and five drains
    localparam int TEST_CYCLES = RST_CYCLES + N_RAND + 20 + 26 + 14 + 14 + 5 * DRAIN_MAX;

    logic              rclk, rrst, wr_en, out_hold, out_valid;
    chan_e             wr_chan, out_chan;
    data_t             wr_data, out_data;
    level_t            level_i, level_q;
    logic [NUM_CH-1:0] full, almost_full, empty, almost_empty, wr_drop;

    // ******************************************************************
    // reference model
    // ******************************************************************

    data_t             q_i [$];          // stored and not yet granted
    data_t             q_q [$];
    logic              exp_valid;        // read in flight after the edge
    chan_e             exp_chan, last_gnt;
    data_t             exp_data;
    logic [NUM_CH-1:0] exp_drop;         // writes lost at the last edge
    chan_e             seen_chan [$];    // order of drained beats
    string             cur_test;
    int                n_checks, n_errors, n_tests, err_mark;

    dual_chan_buffer u_dut (.*);

    initial
    begin
        rclk = 1'b0;
        forever #(CLK_PERIOD / 2) rclk = ~rclk;
    end

    // watchdog at twice the nominal run length
    initial
    begin
        #(2 * TEST_CYCLES * CLK_PERIOD);
        $display("watchdog expired, run still going after %0d cycles", 2 * TEST_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ******************************************************************
    // compare tasks
    // ******************************************************************

    task automatic mismatch(input string what, input string exp, input string act);
        n_errors++;
        $display("[FAIL] %s %s expected %s actual %s", cur_test, what, exp, act);
    endtask

    task automatic check_data(input string what, input data_t exp, input data_t act);
        n_checks++;
        if (act !== exp)
            mismatch(what, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_chan(input string what, input chan_e exp, input chan_e act);
        n_checks++;
        if (act !== exp)
            mismatch(what, $sformatf("%0d", exp), $sformatf("%0d", act));
    endtask

    task automatic check_level(input string what, input level_t exp, input level_t act);
        n_checks++;
        if (act !== exp)
            mismatch(what, $sformatf("%0d", exp), $sformatf("%0d", act));
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        n_checks++;
        if (act !== exp)
            mismatch(what, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    // every output against the model state after an edge
    task automatic check_outputs();
        check_level("level_i", level_t'(q_i.size()), level_i);
        check_level("level_q", level_t'(q_q.size()), level_q);
        check_bit("full_i", q_i.size() == DEPTH, full[0]);
        check_bit("full_q", q_q.size() == DEPTH, full[1]);
        check_bit("empty_i", q_i.size() == 0, empty[0]);
        check_bit("empty_q", q_q.size() == 0, empty[1]);
        check_bit("almost_full_i", q_i.size() >= ALMOST_FULL_NUM, almost_full[0]);
        check_bit("almost_full_q", q_q.size() >= ALMOST_FULL_NUM, almost_full[1]);
        check_bit("almost_empty_i", q_i.size() <= ALMOST_EMPTY_NUM, almost_empty[0]);
        check_bit("almost_empty_q", q_q.size() <= ALMOST_EMPTY_NUM, almost_empty[1]);
        check_bit("wr_drop_i", exp_drop[0], wr_drop[0]);
        check_bit("wr_drop_q", exp_drop[1], wr_drop[1]);
        check_bit("out_valid", exp_valid, out_valid);
        if (exp_valid)
        begin
            check_chan("out_chan", exp_chan, out_chan);   // head of that channel
            check_data("out_data", exp_data, out_data);
        end
    endtask

    // ******************************************************************
    // one cycle: drive, advance the model over the edge, check
    // ******************************************************************

    task automatic step(input logic en, input chan_e ch, input data_t d, input logic hold);
        int   sz_i;
        int   sz_q;
        logic gnt_i;
        logic gnt_q;
        wr_en    = en;
        wr_chan  = ch;
        wr_data  = d;
        out_hold = hold;
        sz_i     = q_i.size();     // counts seen by the flags before the edge
        sz_q     = q_q.size();
        gnt_i    = !hold && sz_i > 0;
        gnt_q    = !hold && sz_q > 0;
        if (gnt_i && gnt_q)
        begin
            gnt_i = (last_gnt == CH_Q);   // tie goes to the one not served last
            gnt_q = !gnt_i;
        end
        exp_valid = gnt_i || gnt_q;       // beat shows one cycle later
        if (gnt_q)
            exp_data = q_q.pop_front();
        else if (gnt_i)
            exp_data = q_i.pop_front();
        if (exp_valid)
        begin
            exp_chan = gnt_q ? CH_Q : CH_I;
            last_gnt = exp_chan;
        end
        exp_drop = '0;
        if (en && ch == CH_I && sz_i >= DEPTH)
            exp_drop[0] = 1'b1;           // full before the edge, sample lost
        else if (en && ch == CH_I)
            q_i.push_back(d);
        if (en && ch == CH_Q && sz_q >= DEPTH)
            exp_drop[1] = 1'b1;
        else if (en && ch == CH_Q)
            q_q.push_back(d);
        @(posedge rclk);
        #1;                               // settled outputs, next drive point
        check_outputs();
    endtask

    // release hold and run until both queues and the read pipe are empty
    task automatic drain();
        int n;
        n = 0;
        seen_chan.delete();
        while ((q_i.size() != 0 || q_q.size() != 0 || exp_valid) && n < DRAIN_MAX)
        begin
            step(1'b0, CH_I, '0, 1'b0);
            if (out_valid)
                seen_chan.push_back(out_chan);
            n++;
        end
        if (q_i.size() != 0 || q_q.size() != 0 || exp_valid)
        begin
            n_errors++;
            $display("%s: queues still hold data after %0d drain cycles", cur_test, n);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_mark = n_errors;
    endtask

    task automatic end_test();
        n_tests++;
        $display("test %-12s %s, %0d errors", cur_test,
                 (n_errors == err_mark) ? "ok" : "failed", n_errors - err_mark);
    endtask

    // ******************************************************************
    // test sequence
    // ******************************************************************

    initial
    begin
        int    k;
        chan_e first_ch;
        void'($urandom(32'h4d4a9460));    // single seed for the run
        rrst      = 1'b1;
        wr_en     = 1'b0;
        wr_chan   = CH_I;
        wr_data   = '0;
        out_hold  = 1'b0;
        exp_valid = 1'b0;
        exp_drop  = '0;
        last_gnt  = CH_Q;                 // first tie after reset goes to I
        n_checks  = 0;
        n_errors  = 0;
        n_tests   = 0;
        repeat (RST_CYCLES) @(posedge rclk);
        #1;
        rrst = 1'b0;

        begin_test("reset");
        check_outputs();
        end_test();

        // mixed writes and stalls, queues run into full now and then
        begin_test("random");
        for (k = 0; k < N_RAND; k++)
            step(($urandom % 4) != 0, ($urandom % 2) ? CH_Q : CH_I, data_t'($urandom),
                 ($urandom % 8) < 3);
        drain();
        end_test();

        // 20 writes into I under hold, last four dropped
        begin_test("full_drop");
        for (k = 0; k < 20; k++)
        begin
            step(1'b1, CH_I, data_t'($urandom), 1'b1);
            check_bit("wr_drop_i", k >= DEPTH, wr_drop[0]);
        end
        check_bit("full_i", 1'b1, full[0]);
        drain();                          // only the 16 stored come out
        end_test();

        // walk both levels through the almost thresholds, Q up to full
        begin_test("levels");
        for (k = 0; k < 26; k++)
            step(1'b1, (k % 3 == 0) ? CH_I : CH_Q, data_t'($urandom), 1'b1);
        drain();
        end_test();

        // preload 5 on I and 9 on Q, first 10 beats must alternate
        begin_test("round_robin");
        for (k = 0; k < 14; k++)
            step(1'b1, (k < 10 && k % 2 == 0) ? CH_I : CH_Q, data_t'($urandom), 1'b1);
        first_ch = (last_gnt == CH_I) ? CH_Q : CH_I;   // the one not served last opens
        drain();
        for (k = 0; k < 10; k++)
            check_chan("alternation", chan_e'(first_ch ^ k[0]), seen_chan[k]);
        end_test();

        // stall with reads in flight, the beat seen here is already the second hold cycle
        begin_test("backpressure");
        for (k = 0; k < 8; k++)
            step(1'b1, (k % 2) ? CH_Q : CH_I, data_t'($urandom), 1'b0);
        for (k = 0; k < 6; k++)
        begin
            step(k % 2 == 0, CH_Q, data_t'($urandom), 1'b1);
            check_bit("out_valid_held", 1'b0, out_valid);
        end
        drain();
        check_bit("empty_i", 1'b1, empty[0]);
        check_bit("empty_q", 1'b1, empty[1]);
        end_test();

        $display("summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule
